// File: sim.f
+incdir+.
ls_pkg.sv
ls_decode.sv
ls_execute.sv
ls_data_mem.sv
ls_result.sv
load_store_unit.sv
tb_load_store_unit.sv

// File: Bender.yml
package:
  name: load_store_unit

export_include_dirs:
  - .

sources:
  - files:
      - ls_pkg.sv
      - ls_decode.sv
      - ls_execute.sv
      - ls_data_mem.sv
      - ls_result.sv
      - load_store_unit.sv
  - target: simulation
    files:
      - tb_load_store_unit.sv

// File: tb_ls_vectors.svh
/*
 * Load/store unit test table
 * Loads, stores, misaligned and illegal instructions with expected results
 */

// load_row takes fn3, rs1, offset and the expected load data
// store_row takes fn3, rs1, offset and rs2
// fault_row takes instruction, rs1, rs2, exception code and expected tval

task automatic build_vectors();
    logic [31:0] r_word;
    logic [31:0] r_byte;
    logic [31:0] r_half;
    logic [31:0] lane_word;

    r_word = lcg_next();
    r_byte = lcg_next();
    // Sign bit set so the upper half tells LH from LHU
    r_half = lcg_next() | 32'h0000_8000;
    lane_word = {8'h07, r_byte[7:0], 8'hC3, 8'h96};

    // A word store gives no output and the load returns it
    store_row(FN3_W, 32'h0000_0100, 12'h000, r_word);
    load_row(FN3_W, 32'h0000_0100, 12'h000, r_word);

    // Byte lanes of the word at 0x200
    store_row(FN3_W, 32'h0000_0200, 12'h000, 32'h1122_3344);
    store_row(FN3_B, 32'h0000_0200, 12'h002, r_byte);
    load_row(FN3_W, 32'h0000_0200, 12'h000, {8'h11, r_byte[7:0], 16'h3344});
    store_row(FN3_B, 32'h0000_0200, 12'h000, 32'hFFFF_FF96);
    load_row(FN3_W, 32'h0000_0200, 12'h000, {8'h11, r_byte[7:0], 16'h3396});
    store_row(FN3_B, 32'h0000_0201, 12'h000, 32'h0000_00C3);
    store_row(FN3_B, 32'h0000_0200, 12'h003, 32'h1234_5607);
    load_row(FN3_W, 32'h0000_0200, 12'h000, lane_word);
    load_row(FN3_BU, 32'h0000_0200, 12'h001, 32'h0000_00C3);
    load_row(FN3_B, 32'h0000_0200, 12'h001, 32'hFFFF_FFC3);
    load_row(FN3_B, 32'h0000_0200, 12'h003, 32'h0000_0007);
    load_row(FN3_BU, 32'h0000_0200, 12'h000, 32'h0000_0096);

    // Halfwords at 0x300 and 0x304
    store_row(FN3_H, 32'h0000_0300, 12'h000, 32'hABCD_8123);
    store_row(FN3_H, 32'h0000_0300, 12'h002, r_half);
    load_row(FN3_W, 32'h0000_0300, 12'h000, {r_half[15:0], 16'h8123});
    load_row(FN3_H, 32'h0000_0300, 12'h000, 32'hFFFF_8123);
    load_row(FN3_HU, 32'h0000_0300, 12'h000, 32'h0000_8123);
    load_row(FN3_H, 32'h0000_0300, 12'h002, {16'hFFFF, r_half[15:0]});
    load_row(FN3_HU, 32'h0000_0300, 12'h002, {16'h0000, r_half[15:0]});
    store_row(FN3_H, 32'h0000_0304, 12'h000, 32'h5555_7ABC);
    load_row(FN3_H, 32'h0000_0304, 12'h000, 32'h0000_7ABC);

    // Misaligned accesses leave memory alone
    fault_row(enc_load(FN3_H, 12'h001), 32'h0000_0300, 32'h0, EXC_LOAD_MISALIGNED, 32'h301);
    fault_row(enc_load(FN3_W, 12'h002), 32'h0000_0300, 32'h0, EXC_LOAD_MISALIGNED, 32'h302);
    fault_row(enc_load(FN3_W, 12'h003), 32'h0000_0300, 32'h0, EXC_LOAD_MISALIGNED, 32'h303);
    fault_row(enc_store(FN3_W, 12'h001), 32'h0000_0200, 32'hDEAD_BEEF,
              EXC_STORE_MISALIGNED, 32'h201);
    fault_row(enc_store(FN3_H, 12'h003), 32'h0000_0200, 32'hDEAD_BEEF,
              EXC_STORE_MISALIGNED, 32'h203);
    load_row(FN3_W, 32'h0000_0200, 12'h000, lane_word);

    // Illegal encodings addi, ld and a store with fn3 100
    fault_row(32'h0050_0093, 32'h0000_0100, 32'h0, EXC_ILLEGAL_INST, 32'h0050_0093);
    fault_row(enc_load(3'b011, 12'h000), 32'h0000_0100, 32'h0,
              EXC_ILLEGAL_INST, enc_load(3'b011, 12'h000));
    fault_row(enc_store(3'b100, 12'h000), 32'h0000_0100, 32'hDEAD_BEEF,
              EXC_ILLEGAL_INST, enc_store(3'b100, 12'h000));
    load_row(FN3_W, 32'h0000_0100, 12'h000, r_word);

    // Negative offsets and addresses past the end wrap onto the memory
    load_row(FN3_W, 32'h0000_0104, 12'hFFC, r_word);
    load_row(FN3_W, 32'h0000_0500, 12'h000, r_word);
    load_row(FN3_W, 32'h8000_0100, 12'h000, r_word);
    store_row(FN3_W, 32'h0000_03FC, 12'h000, 32'hCAFE_F00D);
    load_row(FN3_W, 32'h0000_0000, 12'hFFC, 32'hCAFE_F00D);
    load_row(FN3_B, 32'h0000_0400, 12'h203, 32'h0000_0007);
endtask

// File: tb_load_store_unit.sv
/*
 * Testbench for the load/store unit
 * Runs a table of instructions through the req/ack handshake and
 * checks the writeback and exception outputs of every row
 */

`timescale 1ns/1ns
`include "ls_defs.svh"

module tb_load_store_unit;
    import ls_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int MAX_VECTORS = 64;
    localparam int CYCLES_PER_VECTOR = 20;

    // Expected response of a row
    localparam logic [1:0] KIND_NONE = 2'd0;
    localparam logic [1:0] KIND_WB = 2'd1;
    localparam logic [1:0] KIND_EXC = 2'd2;

    // RV32 fn3 field of loads and stores
    localparam logic [2:0] FN3_B = 3'b000;
    localparam logic [2:0] FN3_H = 3'b001;
    localparam logic [2:0] FN3_W = 3'b010;
    localparam logic [2:0] FN3_BU = 3'b100;
    localparam logic [2:0] FN3_HU = 3'b101;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 req;
    logic [31:0]          instr;
    logic [`LS_XLEN-1:0]  rs1_data;
    logic [`LS_XLEN-1:0]  rs2_data;
    logic [`LS_ID_W-1:0]  id;
    logic                 ack;
    logic                 wb_done;
    logic [`LS_ID_W-1:0]  wb_id;
    logic [`LS_XLEN-1:0]  wb_data;
    logic                 exc_valid;
    logic [`LS_EXC_W-1:0] exc_code;
    logic [`LS_XLEN-1:0]  exc_tval;
    logic [`LS_ID_W-1:0]  exc_id;

    logic [31:0]          vec_instr [MAX_VECTORS];
    logic [31:0]          vec_rs1 [MAX_VECTORS];
    logic [31:0]          vec_rs2 [MAX_VECTORS];
    logic [`LS_ID_W-1:0]  vec_id [MAX_VECTORS];
    logic [1:0]           vec_kind [MAX_VECTORS];
    logic [31:0]          vec_val [MAX_VECTORS];
    logic [`LS_EXC_W-1:0] vec_code [MAX_VECTORS];
    logic [31:0]          vec_tval [MAX_VECTORS];

    int          num_vectors = 0;
    int          cycle = 0;
    int          row_errors = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    logic        table_ready = 1'b0;
    logic [31:0] lcg_state = 32'h1d3fc97c;

    load_store_unit i_load_store_unit (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .instr     (instr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .id        (id),
        .ack       (ack),
        .wb_done   (wb_done),
        .wb_id     (wb_id),
        .wb_data   (wb_data),
        .exc_valid (exc_valid),
        .exc_code  (exc_code),
        .exc_tval  (exc_tval),
        .exc_id    (exc_id)
    );

    always begin
        #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////
    // Stimulus helpers
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Base in x1, rd x2, store data in x3
    function automatic logic [31:0] enc_load(input logic [2:0] fn3, input logic [11:0] imm);
        return {imm, 5'd1, fn3, 5'd2, 7'b0000011};
    endfunction

    function automatic logic [31:0] enc_store(input logic [2:0] fn3, input logic [11:0] imm);
        return {imm[11:5], 5'd3, 5'd1, fn3, imm[4:0], 7'b0100011};
    endfunction

    task automatic add_vec(input logic [31:0] ins, input logic [31:0] rs1,
                           input logic [31:0] rs2, input logic [1:0] kind,
                           input logic [31:0] val, input logic [3:0] code,
                           input logic [31:0] tval);
        vec_instr[num_vectors] = ins;
        vec_rs1[num_vectors] = rs1;
        vec_rs2[num_vectors] = rs2;
        vec_id[num_vectors] = 4'(num_vectors + 1);
        vec_kind[num_vectors] = kind;
        vec_val[num_vectors] = val;
        vec_code[num_vectors] = code;
        vec_tval[num_vectors] = tval;
        num_vectors++;
    endtask

    task automatic load_row(input logic [2:0] fn3, input logic [31:0] rs1,
                            input logic [11:0] imm, input logic [31:0] val);
        add_vec(enc_load(fn3, imm), rs1, 32'h0, KIND_WB, val, 4'd0, 32'h0);
    endtask

    task automatic store_row(input logic [2:0] fn3, input logic [31:0] rs1,
                             input logic [11:0] imm, input logic [31:0] rs2);
        add_vec(enc_store(fn3, imm), rs1, rs2, KIND_NONE, 32'h0, 4'd0, 32'h0);
    endtask

    task automatic fault_row(input logic [31:0] ins, input logic [31:0] rs1,
                             input logic [31:0] rs2, input logic [3:0] code,
                             input logic [31:0] tval);
        add_vec(ins, rs1, rs2, KIND_EXC, 32'h0, code, tval);
    endtask

    `include "tb_ls_vectors.svh"

    ////////////////////////////////////////
    // Checking
    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s: got %h expected %h", $time, name, got, exp);
            row_errors++;
        end
    endtask

    task automatic run_vector(input int n);
        int accept_cycle;

        row_errors = 0;
        @(posedge clk);
        req <= 1'b1;
        instr <= vec_instr[n];
        rs1_data <= vec_rs1[n];
        rs2_data <= vec_rs2[n];
        id <= vec_id[n];

        // Nothing from the previous row may still be showing
        @(negedge clk);
        while (!ack) begin
            if (wb_done || exc_valid) begin
                $display("ERROR t=%0t row %0d: output pulse before acceptance", $time, n);
                row_errors++;
            end
            @(negedge clk);
        end
        accept_cycle = cycle;

        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        if (wb_done || exc_valid) begin
            $display("ERROR t=%0t row %0d: output pulse one edge too early", $time, n);
            row_errors++;
        end
        while (ack) @(negedge clk);
        if (cycle != accept_cycle + 2) begin
            $display("ERROR t=%0t row %0d: ack dropped on the wrong edge", $time, n);
            row_errors++;
        end

        // Third edge counting the accept edge
        if (vec_kind[n] == KIND_WB) begin
            if (!wb_done) begin
                $display("ERROR t=%0t row %0d: load gave no writeback", $time, n);
                row_errors++;
            end else begin
                compare_value("wb_data", wb_data, vec_val[n]);
                compare_value("wb_id", 32'(wb_id), 32'(vec_id[n]));
            end
            if (exc_valid) begin
                $display("ERROR t=%0t row %0d: load raised an exception", $time, n);
                row_errors++;
            end
        end else if (vec_kind[n] == KIND_EXC) begin
            if (!exc_valid) begin
                $display("ERROR t=%0t row %0d: no exception reported", $time, n);
                row_errors++;
            end else begin
                compare_value("exc_code", 32'(exc_code), 32'(vec_code[n]));
                compare_value("exc_tval", exc_tval, vec_tval[n]);
                compare_value("exc_id", 32'(exc_id), 32'(vec_id[n]));
            end
            if (wb_done) begin
                $display("ERROR t=%0t row %0d: faulting access wrote back", $time, n);
                row_errors++;
            end
        end else if (wb_done || exc_valid) begin
            $display("ERROR t=%0t row %0d: store produced an output", $time, n);
            row_errors++;
        end

        if (row_errors == 0) begin
            pass_count++;
            $display("row %0d instr %h id %0d: pass", n, vec_instr[n], vec_id[n]);
        end else begin
            fail_count++;
            $display("row %0d instr %h id %0d: fail", n, vec_instr[n], vec_id[n]);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    initial begin
        rst <= 1'b1;
        req <= 1'b0;
        instr <= 32'h0;
        rs1_data <= '0;
        rs2_data <= '0;
        id <= '0;
        build_vectors();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < num_vectors; n++) begin
            run_vector(n);
        end
        $display("Done: %0d rows passed, %0d rows failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Every row finishes in well under its budget
    initial begin
        wait (table_ready);
        repeat (num_vectors * CYCLES_PER_VECTOR + RESET_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired at cycle %0d, handshake or output stuck", cycle);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: load_store_unit.sv
/*
 * RV32 integer load/store unit
 * Decode, execute and result stages around a local data memory
 */

`timescale 1ns/1ns
`include "ls_defs.svh"

module load_store_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  logic [31:0]          instr,
    input  logic [`LS_XLEN-1:0]  rs1_data,
    input  logic [`LS_XLEN-1:0]  rs2_data,
    input  logic [`LS_ID_W-1:0]  id,
    output logic                 ack,
    output logic                 wb_done,
    output logic [`LS_ID_W-1:0]  wb_id,
    output logic [`LS_XLEN-1:0]  wb_data,
    output logic                 exc_valid,
    output ls_pkg::exc_code_t    exc_code,
    output logic [`LS_XLEN-1:0]  exc_tval,
    output logic [`LS_ID_W-1:0]  exc_id
);
    import ls_pkg::*;

    // Decode to execute
    logic                dec_valid;
    ls_op_t              dec_op;
    logic [`LS_XLEN-1:0] dec_base;
    logic [11:0]         dec_offset;
    logic [`LS_XLEN-1:0] dec_store_data;
    logic [`LS_ID_W-1:0] dec_id;
    logic [31:0]         dec_instr;

    // Execute to data memory
    logic                mem_we;
    logic                mem_re;
    logic [3:0]          mem_be;
    logic [`LS_XLEN-1:0] mem_addr;
    logic [`LS_XLEN-1:0] mem_wdata;
    logic [`LS_XLEN-1:0] mem_rdata;

    // Execute to result
    logic                ex_valid;
    ls_op_t              ex_op;
    logic [1:0]          ex_byte_addr;
    logic [`LS_ID_W-1:0] ex_id;
    logic                ex_exc;
    exc_code_t           ex_exc_code;
    logic [`LS_XLEN-1:0] ex_tval;

    ////////////////////////////////////////
    // Stages
    ls_decode i_ls_decode (
        .clk            (clk),
        .rst            (rst),
        .req            (req),
        .instr          (instr),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .id             (id),
        .ack            (ack),
        .dec_valid      (dec_valid),
        .dec_op         (dec_op),
        .dec_base       (dec_base),
        .dec_offset     (dec_offset),
        .dec_store_data (dec_store_data),
        .dec_id         (dec_id),
        .dec_instr      (dec_instr)
    );

    ls_execute i_ls_execute (
        .clk            (clk),
        .rst            (rst),
        .dec_valid      (dec_valid),
        .dec_op         (dec_op),
        .dec_base       (dec_base),
        .dec_offset     (dec_offset),
        .dec_store_data (dec_store_data),
        .dec_id         (dec_id),
        .dec_instr      (dec_instr),
        .mem_we         (mem_we),
        .mem_re         (mem_re),
        .mem_be         (mem_be),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .ex_valid       (ex_valid),
        .ex_op          (ex_op),
        .ex_byte_addr   (ex_byte_addr),
        .ex_id          (ex_id),
        .ex_exc         (ex_exc),
        .ex_exc_code    (ex_exc_code),
        .ex_tval        (ex_tval)
    );

    ls_data_mem #(
        .MEM_WORDS (`LS_MEM_WORDS)
    ) i_ls_data_mem (
        .clk       (clk),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_be    (mem_be),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    ls_result i_ls_result (
        .clk          (clk),
        .rst          (rst),
        .ex_valid     (ex_valid),
        .ex_op        (ex_op),
        .ex_byte_addr (ex_byte_addr),
        .ex_id        (ex_id),
        .ex_exc       (ex_exc),
        .ex_exc_code  (ex_exc_code),
        .ex_tval      (ex_tval),
        .mem_rdata    (mem_rdata),
        .wb_done      (wb_done),
        .wb_id        (wb_id),
        .wb_data      (wb_data),
        .exc_valid    (exc_valid),
        .exc_code     (exc_code),
        .exc_tval     (exc_tval),
        .exc_id       (exc_id)
    );

endmodule

// File: ls_result.sv
/*
 * Load/store result stage
 * Aligns and extends load data, then reports a writeback
 * or an exception for one cycle
 */

`timescale 1ns/1ns
`include "ls_defs.svh"

module ls_result (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ex_valid,
    input  ls_pkg::ls_op_t       ex_op,
    input  logic [1:0]           ex_byte_addr,
    input  logic [`LS_ID_W-1:0]  ex_id,
    input  logic                 ex_exc,
    input  ls_pkg::exc_code_t    ex_exc_code,
    input  logic [`LS_XLEN-1:0]  ex_tval,
    input  logic [`LS_XLEN-1:0]  mem_rdata,
    output logic                 wb_done,
    output logic [`LS_ID_W-1:0]  wb_id,
    output logic [`LS_XLEN-1:0]  wb_data,
    output logic                 exc_valid,
    output ls_pkg::exc_code_t    exc_code,
    output logic [`LS_XLEN-1:0]  exc_tval,
    output logic [`LS_ID_W-1:0]  exc_id
);
    import ls_pkg::*;

    logic [7:0]          byte_sel;
    logic [15:0]         half_sel;
    logic [`LS_XLEN-1:0] load_data;
    logic                is_load;

    ////////////////////////////////////////
    // Lane select, alignment already checked
    assign byte_sel = mem_rdata[ex_byte_addr*8 +: 8];
    assign half_sel = ex_byte_addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    always_comb begin
        case (ex_op)
            LS_LB:   load_data = {{24{byte_sel[7]}}, byte_sel};
            LS_LBU:  load_data = {24'd0, byte_sel};
            LS_LH:   load_data = {{16{half_sel[15]}}, half_sel};
            LS_LHU:  load_data = {16'd0, half_sel};
            default: load_data = mem_rdata;
        endcase
    end

    assign is_load = ex_op inside {LS_LB, LS_LH, LS_LW, LS_LBU, LS_LHU};

    ////////////////////////////////////////
    // Output registers
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_done <= 1'b0;
            exc_valid <= 1'b0;
        end else begin
            wb_done <= ex_valid && is_load && !ex_exc;
            exc_valid <= ex_valid && ex_exc;
        end
    end

    always_ff @(posedge clk) begin
        wb_id <= ex_id;
        wb_data <= load_data;
        exc_code <= ex_exc_code;
        exc_tval <= ex_tval;
        exc_id <= ex_id;
    end

endmodule

// File: ls_data_mem.sv
/*
 * Tightly coupled data memory
 * Word wide, byte-enabled writes, one cycle read latency
 */

`timescale 1ns/1ns
`include "ls_defs.svh"

module ls_data_mem #(
    parameter int MEM_WORDS = `LS_MEM_WORDS
) (
    input  logic                 clk,
    input  logic                 mem_we,
    input  logic                 mem_re,
    input  logic [3:0]           mem_be,
    input  logic [`LS_XLEN-1:0]  mem_addr,
    input  logic [`LS_XLEN-1:0]  mem_wdata,
    output logic [`LS_XLEN-1:0]  mem_rdata
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [`LS_XLEN-1:0] mem [MEM_WORDS];
    logic [IDX_W-1:0]    idx;

    // Word index, higher bits wrap
    assign idx = mem_addr[2 +: IDX_W];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            for (int i = 0; i < 4; i++) begin
                if (mem_be[i])
                    mem[idx][i*8 +: 8] <= mem_wdata[i*8 +: 8];
            end
        end
        if (mem_re)
            mem_rdata <= mem[idx];
    end

endmodule

// File: ls_execute.sv
/*
 * Load/store execute stage
 * Forms the address, checks alignment, drives the data memory
 * and registers the attributes needed to finish the access
 */

`timescale 1ns/1ns
`include "ls_defs.svh"

module ls_execute (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dec_valid,
    input  ls_pkg::ls_op_t       dec_op,
    input  logic [`LS_XLEN-1:0]  dec_base,
    input  logic [11:0]          dec_offset,
    input  logic [`LS_XLEN-1:0]  dec_store_data,
    input  logic [`LS_ID_W-1:0]  dec_id,
    input  logic [31:0]          dec_instr,
    output logic                 mem_we,
    output logic                 mem_re,
    output logic [3:0]           mem_be,
    output logic [`LS_XLEN-1:0]  mem_addr,
    output logic [`LS_XLEN-1:0]  mem_wdata,
    output logic                 ex_valid,
    output ls_pkg::ls_op_t       ex_op,
    output logic [1:0]           ex_byte_addr,
    output logic [`LS_ID_W-1:0]  ex_id,
    output logic                 ex_exc,
    output ls_pkg::exc_code_t    ex_exc_code,
    output logic [`LS_XLEN-1:0]  ex_tval
);
    import ls_pkg::*;

    logic [`LS_XLEN-1:0] addr;
    logic                is_load;
    logic                is_store;
    logic                illegal;
    logic                misaligned;
    logic                exc;
    logic [3:0]          be;
    exc_code_t           exc_code;

    ////////////////////////////////////////
    // Address and alignment
    assign addr = dec_base + {{(`LS_XLEN-12){dec_offset[11]}}, dec_offset};

    assign is_load = dec_op inside {LS_LB, LS_LH, LS_LW, LS_LBU, LS_LHU};
    assign is_store = dec_op inside {LS_SB, LS_SH, LS_SW};
    assign illegal = (dec_op == LS_ILLEGAL);

    always_comb begin
        case (dec_op)
            LS_LH, LS_LHU, LS_SH: misaligned = addr[0];
            LS_LW, LS_SW:         misaligned = |addr[1:0];
            default:              misaligned = 1'b0;
        endcase
    end

    assign exc = illegal || misaligned;

    ////////////////////////////////////////
    // Byte enables and store lanes
    always_comb begin
        case (dec_op)
            LS_SB: begin
                be = 4'b0001 << addr[1:0];
                mem_wdata = {4{dec_store_data[7:0]}};
            end
            LS_SH: begin
                be = addr[1] ? 4'b1100 : 4'b0011;
                mem_wdata = {2{dec_store_data[15:0]}};
            end
            default: begin
                be = 4'b1111;
                mem_wdata = dec_store_data;
            end
        endcase
    end

    // No access at all when the instruction faults
    assign mem_re = dec_valid && is_load && !exc;
    assign mem_we = dec_valid && is_store && !exc;
    assign mem_be = mem_we ? be : 4'b0000;
    assign mem_addr = addr;

    always_comb begin
        if (illegal)
            exc_code = EXC_ILLEGAL_INST;
        else if (is_load)
            exc_code = EXC_LOAD_MISALIGNED;
        else
            exc_code = EXC_STORE_MISALIGNED;
    end

    ////////////////////////////////////////
    // Attributes for the result stage
    always_ff @(posedge clk) begin
        if (rst)
            ex_valid <= 1'b0;
        else
            ex_valid <= dec_valid;
    end

    always_ff @(posedge clk) begin
        ex_op <= dec_op;
        ex_byte_addr <= addr[1:0];
        ex_id <= dec_id;
        ex_exc <= exc;
        ex_exc_code <= exc_code;
        ex_tval <= illegal ? dec_instr : addr;
    end

endmodule

// File: ls_decode.sv
/*
 * Load/store decode stage
 * Accepts one instruction per four-phase req/ack cycle and
 * registers the decoded operation, offset and operands
 */

`timescale 1ns/1ns
`include "ls_defs.svh"

module ls_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  logic [31:0]          instr,
    input  logic [`LS_XLEN-1:0]  rs1_data,
    input  logic [`LS_XLEN-1:0]  rs2_data,
    input  logic [`LS_ID_W-1:0]  id,
    output logic                 ack,
    output logic                 dec_valid,
    output ls_pkg::ls_op_t       dec_op,
    output logic [`LS_XLEN-1:0]  dec_base,
    output logic [11:0]          dec_offset,
    output logic [`LS_XLEN-1:0]  dec_store_data,
    output logic [`LS_ID_W-1:0]  dec_id,
    output logic [31:0]          dec_instr
);
    import ls_pkg::*;

    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    hs_state_t   state;
    logic        accept;
    ls_op_t      op;
    logic [11:0] offset;

    ////////////////////////////////////////
    // Handshake
    assign accept = (state == HS_IDLE) && req;
    assign ack = (state == HS_ACK);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= HS_IDLE;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= accept;
            if (accept)
                state <= HS_ACK;
            else if (state == HS_ACK && !req)
                state <= HS_IDLE;
        end
    end

    ////////////////////////////////////////
    // Opcode and fn3 to operation
    always_comb begin
        op = LS_ILLEGAL;
        if (instr[6:0] == OPC_LOAD) begin
            case (instr[14:12])
                3'b000: op = LS_LB;
                3'b001: op = LS_LH;
                3'b010: op = LS_LW;
                3'b100: op = LS_LBU;
                3'b101: op = LS_LHU;
                default: op = LS_ILLEGAL;
            endcase
        end else if (instr[6:0] == OPC_STORE) begin
            case (instr[14:12])
                3'b000: op = LS_SB;
                3'b001: op = LS_SH;
                3'b010: op = LS_SW;
                default: op = LS_ILLEGAL;
            endcase
        end
    end

    // S-type splits the immediate around rd
    assign offset = instr[5] ? {instr[31:25], instr[11:7]} : instr[31:20];

    // Issue slot
    always_ff @(posedge clk) begin
        if (accept) begin
            dec_op <= op;
            dec_base <= rs1_data;
            dec_offset <= offset;
            dec_store_data <= rs2_data;
            dec_id <= id;
            dec_instr <= instr;
        end
    end

endmodule

// File: ls_pkg.sv
/*
 * Load/store unit types
 * Opcode, exception code and handshake state enums
 */

`include "ls_defs.svh"

package ls_pkg;

    ////////////////////////////////////////
    // Decoded operation
    typedef enum logic [3:0] {
        LS_LB,
        LS_LH,
        LS_LW,
        LS_LBU,
        LS_LHU,
        LS_SB,
        LS_SH,
        LS_SW,
        LS_ILLEGAL
    } ls_op_t;

    ////////////////////////////////////////
    // Exception causes reported by the unit
    typedef enum logic [`LS_EXC_W-1:0] {
        EXC_ILLEGAL_INST     = `LS_EXC_W'(`LS_EXC_ILLEGAL_INST),
        EXC_LOAD_MISALIGNED  = `LS_EXC_W'(`LS_EXC_LOAD_MISALIGNED),
        EXC_STORE_MISALIGNED = `LS_EXC_W'(`LS_EXC_STORE_MISALIGNED)
    } exc_code_t;

    ////////////////////////////////////////
    // Four-phase request acceptance
    typedef enum logic {
        HS_IDLE,
        HS_ACK
    } hs_state_t;

endpackage

// File: ls_defs.svh
/*
 * Load/store unit shared parameters
 * Data width, id width, data memory depth and exception encodings
 */

`ifndef LS_DEFS_SVH
`define LS_DEFS_SVH

// Data and address width
`define LS_XLEN 32

// Instruction id carried through to writeback
`define LS_ID_W 4

// Data memory depth in words, upper address bits wrap
`define LS_MEM_WORDS 256

// Exception code width and RISC-V mcause values
`define LS_EXC_W 4
`define LS_EXC_ILLEGAL_INST 2
`define LS_EXC_LOAD_MISALIGNED 4
`define LS_EXC_STORE_MISALIGNED 6

`endif
